// ==== emu_config.svh ====
`ifndef EMU_CONFIG_SVH
`define EMU_CONFIG_SVH

// Register bus widths
`define EMU_ADDR_W 12
`define EMU_DATA_W 32

// Number of trigger lines coming from the emulated design
`define EMU_TRIG_W 32

// Register byte offsets
`define EMU_STAT        12'h000
`define EMU_TRIG_STAT   12'h004
`define EMU_CYCLE_LO    12'h008
`define EMU_CYCLE_HI    12'h00C
`define EMU_STEP        12'h010

// AXI-lite response codes
`define AXIL_RESP_OKAY      2'b00
`define AXIL_RESP_SLVERR    2'b10

// Width of the emulated-cycle counter, read in two halves
`define EMU_CYCLE_W 64

// Strobe value that marks a full-word write
`define EMU_FULL_STRB 4'b1111

`endif

// ==== emu_pkg.sv ====
`include "emu_config.svh"

package emu_pkg;

    // One register write as seen by the register block
    typedef struct packed {
        logic [`EMU_ADDR_W-1:0] addr;
        logic [`EMU_DATA_W-1:0] data;
    } csr_wr_t;

    // EMU_STAT layout
    //   bit 31   step_trig, read only
    //   bit 1    DUT reset
    //   bit 0    halt
    typedef struct packed {
        logic        step_trig;
        logic [28:0] reserved;
        logic        dut_reset;
        logic        halt;
    } emu_stat_t;

endpackage

// ==== csr_axil_slave.sv ====
`timescale 1ns/10ps

`include "emu_config.svh"

module csr_axil_slave (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`EMU_ADDR_W-1:0]  awaddr,
    input  logic [2:0]              awprot,
    input  logic                    wvalid,
    output logic                    wready,
    input  logic [`EMU_DATA_W-1:0]  wdata,
    input  logic [3:0]              wstrb,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp,

    input  logic                    arvalid,
    output logic                    arready,
    input  logic [`EMU_ADDR_W-1:0]  araddr,
    input  logic [2:0]              arprot,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [`EMU_DATA_W-1:0]  rdata,
    output logic [1:0]              rresp,

    output logic                    wr_en,
    output emu_pkg::csr_wr_t        wr,
    output logic [`EMU_ADDR_W-1:0]  rd_addr,
    input  logic [`EMU_DATA_W-1:0]  rd_data
);
    import emu_pkg::*;

    csr_wr_t                wr_q;
    logic                   aw_held;
    logic                   w_held;
    logic                   wr_err;
    logic                   b_pend;
    logic [1:0]             b_resp_q;
    logic                   wr_both;

    logic [`EMU_ADDR_W-1:0] ar_addr;
    logic [`EMU_DATA_W-1:0] r_data;
    logic                   ar_held;
    logic                   r_held;

    // Address and data both present, write completes this edge
    assign wr_both = aw_held && w_held;

    // awprot and arprot carry no meaning for these registers
    assign awready = !aw_held && !b_pend;
    assign wready  = !w_held;
    assign bvalid  = b_pend;
    assign bresp   = b_resp_q;

    assign wr_en   = wr_both && !wr_err;
    assign wr      = wr_q;

    always_ff @(posedge clk) begin
        if (awvalid && awready) begin
            wr_q.addr <= awaddr;
        end
        if (wvalid && wready) begin
            wr_q.data <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            wr_err   <= 1'b0;
            b_pend   <= 1'b0;
            b_resp_q <= `AXIL_RESP_OKAY;
        end else begin
            if (awvalid && awready) begin
                aw_held <= 1'b1;
            end
            if (wvalid && wready) begin
                w_held <= 1'b1;
                wr_err <= wstrb != `EMU_FULL_STRB;
            end
            // Response code is frozen here so a new W beat cannot disturb it
            if (wr_both) begin
                aw_held  <= 1'b0;
                w_held   <= 1'b0;
                b_pend   <= 1'b1;
                b_resp_q <= wr_err ? `AXIL_RESP_SLVERR : `AXIL_RESP_OKAY;
            end
            if (bvalid && bready) begin
                b_pend <= 1'b0;
            end
        end
    end

    // Read side
    assign arready = !ar_held;
    assign rvalid  = r_held;
    assign rdata   = r_data;
    assign rresp   = `AXIL_RESP_OKAY;
    assign rd_addr = ar_addr;

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            ar_addr <= araddr;
        end
        if (ar_held && !r_held) begin
            r_data <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_held <= 1'b0;
            r_held  <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                ar_held <= 1'b1;
            end
            if (ar_held && !r_held) begin
                r_held <= 1'b1;
            end
            if (rvalid && rready) begin
                ar_held <= 1'b0;
                r_held  <= 1'b0;
            end
        end
    end

    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp));

    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata));

    // A W beat with a partial strobe never produces a write pulse
    a_no_wr_on_err: assert property (@(posedge clk) disable iff (rst)
        wvalid && wready && wstrb != `EMU_FULL_STRB |=> !wr_en);

endmodule

// ==== emu_ctrl_regs.sv ====
`timescale 1ns/10ps

`include "emu_config.svh"

module emu_ctrl_regs (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    wr_en,
    input  emu_pkg::csr_wr_t        wr,
    input  logic [`EMU_ADDR_W-1:0]  rd_addr,
    output logic [`EMU_DATA_W-1:0]  rd_data,

    input  logic [`EMU_TRIG_W-1:0]  dut_trig,
    output logic                    halt,
    output logic                    dut_reset
);
    import emu_pkg::*;

    emu_stat_t              stat;
    logic                   step_trig_q;
    logic [`EMU_TRIG_W-1:0] trig_stat;
    logic [`EMU_CYCLE_W-1:0] cycle;
    logic [`EMU_DATA_W-1:0] step;
    logic [`EMU_DATA_W-1:0] step_next;
    logic                   step_trig;
    logic                   trigger;

    logic                   wr_stat;
    logic                   wr_cycle_lo;
    logic                   wr_cycle_hi;
    logic                   wr_step;

    // Register address decode for the write pulse
    assign wr_stat     = wr_en && wr.addr == `EMU_STAT;
    assign wr_cycle_lo = wr_en && wr.addr == `EMU_CYCLE_LO;
    assign wr_cycle_hi = wr_en && wr.addr == `EMU_CYCLE_HI;
    assign wr_step     = wr_en && wr.addr == `EMU_STEP;

    // Step counter only moves while the design runs
    always_comb begin
        if (halt) begin
            step_next = step;
        end else if (step != '0) begin
            step_next = step - 1'b1;
        end else begin
            step_next = '0;
        end
    end

    // Fires on the cycle the count goes from one to zero
    assign step_trig = step != '0 && step_next == '0;
    assign trigger   = step_trig || |dut_trig;

    // Halt, DUT reset and the step-trigger flag
    always_ff @(posedge clk) begin
        if (rst) begin
            halt        <= 1'b1;
            dut_reset   <= 1'b1;
            step_trig_q <= 1'b0;
        end else if (trigger) begin
            // Trigger wins over a STAT write in the same cycle
            halt        <= 1'b1;
            step_trig_q <= step_trig;
        end else if (wr_stat) begin
            halt      <= wr.data[0];
            dut_reset <= wr.data[1];
        end
    end

    // Trigger lines seen at the last trigger
    always_ff @(posedge clk) begin
        if (rst) begin
            trig_stat <= '0;
        end else if (trigger) begin
            trig_stat <= dut_trig;
        end
    end

    // Emulated-cycle counter, loadable in halves while halted
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else if (!halt) begin
            cycle <= cycle + 1'b1;
        end else begin
            if (wr_cycle_lo) begin
                cycle[31:0] <= wr.data;
            end
            if (wr_cycle_hi) begin
                cycle[63:32] <= wr.data;
            end
        end
    end

    // Step register, a write overrides the decrement
    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
        end else if (wr_step) begin
            step <= wr.data;
        end else begin
            step <= step_next;
        end
    end

    always_comb begin
        stat           = '0;
        stat.step_trig = step_trig_q;
        stat.dut_reset = dut_reset;
        stat.halt      = halt;
    end

    // Read mux, unmapped offsets give zero
    always_comb begin
        case (rd_addr)
            `EMU_STAT:      rd_data = stat;
            `EMU_TRIG_STAT: rd_data = trig_stat;
            `EMU_CYCLE_LO:  rd_data = cycle[31:0];
            `EMU_CYCLE_HI:  rd_data = cycle[63:32];
            `EMU_STEP:      rd_data = step;
            default:        rd_data = '0;
        endcase
    end

    // Any trigger stops the design on the next edge
    a_trig_halt: assert property (@(posedge clk) disable iff (rst)
        trigger |=> halt);

endmodule

// ==== emu_system.sv ====
`timescale 1ns/10ps

`include "emu_config.svh"

module emu_system (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`EMU_ADDR_W-1:0]  awaddr,
    input  logic [2:0]              awprot,
    input  logic                    wvalid,
    output logic                    wready,
    input  logic [`EMU_DATA_W-1:0]  wdata,
    input  logic [3:0]              wstrb,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp,

    input  logic                    arvalid,
    output logic                    arready,
    input  logic [`EMU_ADDR_W-1:0]  araddr,
    input  logic [2:0]              arprot,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [`EMU_DATA_W-1:0]  rdata,
    output logic [1:0]              rresp,

    input  logic [`EMU_TRIG_W-1:0]  dut_trig,
    output logic                    halt,
    output logic                    dut_reset
);
    import emu_pkg::*;

    logic                   wr_en;
    csr_wr_t                wr;
    logic [`EMU_ADDR_W-1:0] rd_addr;
    logic [`EMU_DATA_W-1:0] rd_data;

    csr_axil_slave u_slave (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .awprot  (awprot),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .arprot  (arprot),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .wr_en   (wr_en),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    emu_ctrl_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr        (wr),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .dut_trig  (dut_trig),
        .halt      (halt),
        .dut_reset (dut_reset)
    );

endmodule

// ==== emu_system_tb.sv ====
`timescale 1ns/10ps

`include "emu_config.svh"

module emu_system_tb;
    import emu_pkg::*;

    localparam int N_RAND     = 60;
    localparam int N_STRB     = 12;
    localparam int N_STEP     = 8;
    localparam int N_TRIG     = 6;
    localparam int HS_LIMIT   = 16;
    localparam int TXN_CYCLES = 24;
    localparam int N_TXN      = 8 + N_RAND * 2 + N_STRB * 2 + N_STEP * 9 + N_TRIG * 5;
    // Step runs last up to 65 cycles, trigger waits up to 8
    localparam longint WATCHDOG_NS =
        40 * (N_TXN * TXN_CYCLES + N_STEP * 80 + N_TRIG * 16 + 50);

    logic                   clk;
    logic                   rst;
    logic                   awvalid;
    logic                   awready;
    logic [`EMU_ADDR_W-1:0] awaddr;
    logic [2:0]             awprot;
    logic                   wvalid;
    logic                   wready;
    logic [`EMU_DATA_W-1:0] wdata;
    logic [3:0]             wstrb;
    logic                   bvalid;
    logic                   bready;
    logic [1:0]             bresp;
    logic                   arvalid;
    logic                   arready;
    logic [`EMU_ADDR_W-1:0] araddr;
    logic [2:0]             arprot;
    logic                   rvalid;
    logic                   rready;
    logic [`EMU_DATA_W-1:0] rdata;
    logic [1:0]             rresp;
    logic [`EMU_TRIG_W-1:0] dut_trig;
    logic                   halt;
    logic                   dut_reset;

    logic [31:0] lfsr;
    int          checks;
    int          val_errs;
    int          hs_errs;

    // Reference model of the control registers
    logic        m_halt;
    logic        m_dut_reset;
    logic        m_step_trig;
    logic [31:0] m_trig_stat;
    logic [31:0] m_step;
    logic [63:0] m_cycle;

    emu_system dut_i (.*);

    always #20 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic compare(input string what, input logic [31:0] got,
                           input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            val_errs++;
            $display("FAIL at %0t ns: %s is 0x%08h, expected 0x%08h",
                     $time, what, got, expected);
        end
    endtask

    function automatic logic hs_sig(input int which);
        case (which)
            0:       return awready;
            1:       return wready;
            2:       return bvalid;
            3:       return arready;
            default: return rvalid;
        endcase
    endfunction

    // Polls at falling edges where the DUT outputs are settled
    task automatic wait_high(input int which, input string name);
        int n;
        n = 0;
        while (!hs_sig(which) && n < HS_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!hs_sig(which)) begin
            hs_errs++;
            $display("At %0t ns %s stayed low for %0d cycles", $time, name, HS_LIMIT);
        end
    endtask

    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        int gap;
        int dly;
        gap = rand_bits(2);
        dly = rand_bits(2);
        @(negedge clk);
        awvalid = 1'b1;
        awaddr  = addr;
        awprot  = 3'(rand_bits(3));
        wait_high(0, "awready");
        @(negedge clk);
        awvalid = 1'b0;
        repeat (gap) @(negedge clk);
        wvalid = 1'b1;
        wdata  = data;
        wstrb  = strb;
        wait_high(1, "wready");
        @(negedge clk);
        wvalid = 1'b0;
        wait_high(2, "bvalid");
        repeat (dly) @(negedge clk);
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data);
        int dly;
        dly = rand_bits(2);
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        arprot  = 3'(rand_bits(3));
        wait_high(3, "arready");
        @(negedge clk);
        arvalid = 1'b0;
        wait_high(4, "rvalid");
        repeat (dly) @(negedge clk);
        data = rdata;
        compare("read response", 32'(rresp), 32'(`AXIL_RESP_OKAY));
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        emu_stat_t s;
        s           = '0;
        s.step_trig = m_step_trig;
        s.dut_reset = m_dut_reset;
        s.halt      = m_halt;
        case (addr)
            `EMU_STAT:      return s;
            `EMU_TRIG_STAT: return m_trig_stat;
            `EMU_CYCLE_LO:  return m_cycle[31:0];
            `EMU_CYCLE_HI:  return m_cycle[63:32];
            `EMU_STEP:      return m_step;
            default:        return '0;
        endcase
    endfunction

    task automatic write_okay(input logic [11:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axil_write(addr, data, `EMU_FULL_STRB, resp);
        compare("write response", 32'(resp), 32'(`AXIL_RESP_OKAY));
        case (addr)
            `EMU_STAT: begin
                m_halt      = data[0];
                m_dut_reset = data[1];
            end
            // Cycle halves only load while halted
            `EMU_CYCLE_LO: if (m_halt) m_cycle[31:0] = data;
            `EMU_CYCLE_HI: if (m_halt) m_cycle[63:32] = data;
            `EMU_STEP:     m_step = data;
            default: ;
        endcase
    endtask

    task automatic check_reg(input logic [11:0] addr);
        logic [31:0] v;
        axil_read(addr, v);
        compare($sformatf("register 0x%03h", addr), v, model_read(addr));
    endtask

    initial begin
        int          sel;
        int          n;
        logic [11:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [1:0]  resp;
        logic [31:0] pat;
        lfsr = 32'h6ecc;
        checks = 0;
        val_errs = 0;
        hs_errs = 0;
        clk = 1'b0;
        rst = 1'b1;
        awvalid = 1'b0;
        awaddr = '0;
        awprot = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        arprot = '0;
        rready = 1'b0;
        dut_trig = '0;
        m_halt = 1'b1;
        m_dut_reset = 1'b1;
        m_step_trig = 1'b0;
        m_trig_stat = '0;
        m_step = '0;
        m_cycle = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // State straight out of reset
        compare("halt", 32'(halt), 32'h1);
        compare("dut_reset", 32'(dut_reset), 32'h1);
        compare("bvalid", 32'(bvalid), 32'h0);
        compare("rvalid", 32'(rvalid), 32'h0);
        compare("ready flags", {29'h0, awready, wready, arready}, 32'h7);
        for (int k = 0; k < 5; k++) begin
            check_reg(12'(4 * k));
        end

        // Random register traffic, halt kept set
        for (int i = 0; i < N_RAND; i++) begin
            sel  = rand_bits(3);
            data = rand_bits(32);
            case (sel)
                0: begin
                    addr = `EMU_STAT;
                    data = data | 32'h1;
                end
                1: addr = `EMU_CYCLE_LO;
                2: addr = `EMU_CYCLE_HI;
                3: addr = `EMU_STEP;
                4: addr = 12'h014 + 12'(4 * rand_bits(8));
                default: addr = 12'(4 * (rand_bits(3) % 5));
            endcase
            if (sel < 5) begin
                write_okay(addr, data);
            end
            check_reg(addr);
            compare("dut_reset output", 32'(dut_reset), 32'(m_dut_reset));
            compare("halt output", 32'(halt), 32'h1);
        end

        // Partial strobes are refused
        for (int i = 0; i < N_STRB; i++) begin
            case (rand_bits(2))
                0: addr = `EMU_STAT;
                1: addr = `EMU_CYCLE_LO;
                2: addr = `EMU_CYCLE_HI;
                default: addr = `EMU_STEP;
            endcase
            strb = 4'(rand_bits(4));
            if (strb == `EMU_FULL_STRB) strb = 4'h7;
            axil_write(addr, rand_bits(32), strb, resp);
            compare("partial strobe response", 32'(resp), 32'(`AXIL_RESP_SLVERR));
            check_reg(addr);
        end

        // Step runs from a preset cycle count
        for (int i = 0; i < N_STEP; i++) begin
            write_okay(`EMU_CYCLE_LO, rand_bits(32));
            write_okay(`EMU_CYCLE_HI, rand_bits(32));
            n = rand_bits(6) + 1;
            write_okay(`EMU_STEP, 32'(n));
            data = rand_bits(32) & ~32'h1;
            write_okay(`EMU_STAT, data);
            sel = 0;
            while (!halt && sel < 200) begin
                @(negedge clk);
                sel++;
            end
            if (!halt) begin
                hs_errs++;
                $display("At %0t ns halt did not return after a step run of %0d", $time, n);
            end
            m_cycle     = m_cycle + 64'(n);
            m_step      = '0;
            m_step_trig = 1'b1;
            m_halt      = 1'b1;
            m_trig_stat = '0;
            for (int k = 0; k < 5; k++) begin
                check_reg(12'(4 * k));
            end
            compare("dut_reset output", 32'(dut_reset), 32'(data[1]));
        end

        // Free run stopped by a one-cycle trigger pulse
        for (int i = 0; i < N_TRIG; i++) begin
            write_okay(`EMU_STEP, 32'h0);
            data = rand_bits(32) & ~32'h1;
            write_okay(`EMU_STAT, data);
            repeat (rand_bits(3)) @(negedge clk);
            compare("halt while running", 32'(halt), 32'h0);
            pat = rand_bits(32);
            if (pat == '0) pat = 32'h1;
            dut_trig = pat;
            @(negedge clk);
            dut_trig = '0;
            compare("halt after trigger", 32'(halt), 32'h1);
            compare("dut_reset after trigger", 32'(dut_reset), 32'(data[1]));
            m_halt      = 1'b1;
            m_trig_stat = pat;
            m_step_trig = 1'b0;
            check_reg(`EMU_STAT);
            check_reg(`EMU_TRIG_STAT);
            check_reg(`EMU_STEP);
        end

        repeat (2) @(negedge clk);
        $display("Checks: %0d, value errors: %0d, handshake errors: %0d",
                 checks, val_errs, hs_errs);
        if (val_errs == 0 && hs_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the test did not complete", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+.
emu_pkg.sv
csr_axil_slave.sv
emu_ctrl_regs.sv
emu_system.sv
emu_system_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module emu_system_tb \
    -f sources.f \
    -o emu_sim

./obj_dir/emu_sim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "run.sh: simulation reported failure"
    exit 1
fi

echo "run.sh: simulation passed"
exit 0
